// ==== hw/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    localparam int TAG_W = 6;                   // Tag space covers up to 64 entries

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,                        // a + b
        OP_SUB   = 3'd1,                        // a - b, wraps mod 2^32
        OP_XOR   = 3'd2,                        // a ^ b
        OP_MUL   = 3'd3,                        // Iterative shift-add, 12 cycles
        OP_FAULT = 3'd4                         // Raises exception at commit
    } rob_op_e;

    typedef struct packed {
        rob_op_e     op;                        // Bits 31:29
        logic [4:0]  dest;                      // Destination register
        logic [11:0] a;                         // Operand a, zero extended
        logic [11:0] b;                         // Operand b, zero extended
    } instr_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;                  // ROB slot of this instruction
        instr_t           instr;
    } issue_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;                  // Writeback target
        logic [31:0]      value;
        logic             fault;
    } result_t;

    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] value;                     // Zero on exception
        logic        exception;
    } commit_t;

endpackage

`default_nettype wire

// ==== hw/rob_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_dispatch #(
    parameter int NUM_LANES = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [31:0]               wb_dat_w,
    output logic                      wb_ack,
    output logic [31:0]               wb_dat_r,
    input  logic                      rob_full,
    input  logic                      flush,
    input  logic [rob_pkg::TAG_W-1:0] alloc_tag,
    output logic                      alloc,
    output logic                      alloc_fault,
    output logic [4:0]                alloc_dest,
    input  logic [NUM_LANES-1:0]      lane_busy,
    output logic [NUM_LANES-1:0]      issue_valid,
    output rob_pkg::issue_t           issue
);

    rob_pkg::instr_t        instr;              // Write data seen as instruction
    logic [NUM_LANES-1:0]   idle;
    logic [NUM_LANES-1:0]   pick;               // One-hot lowest idle lane
    logic                   wr_ok;
    logic                   req;
    logic                   ack_q;

    assign instr = rob_pkg::instr_t'(wb_dat_w);
    assign idle  = ~lane_busy;
    assign pick  = idle & (~idle + 1'b1);       // Isolate lowest set bit

    // Writes need a free ROB slot and an idle lane
    assign wr_ok = !rob_full && (|idle);
    assign req   = wb_cyc && wb_stb && (!wb_we || wr_ok) && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req && !ack_q;             // One-cycle pulse that never repeats back to back
        end
    end

    assign wb_ack   = ack_q && !flush;          // Exception flush cancels this accept
    assign wb_dat_r = 32'd0;                    // Reads return zero

    // Accept happens in the ack cycle; state can only free up since the request
    assign alloc       = wb_ack && wb_we;
    assign alloc_dest  = instr.dest;
    assign alloc_fault = (instr.op == rob_pkg::OP_FAULT);

    assign issue.tag   = alloc_tag;             // Current ROB tail
    assign issue.instr = instr;
    assign issue_valid = alloc ? pick : '0;     // Shared bundle with one lane strobed

    a_ack_needs_stb: assert property (
        @(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> wb_cyc && wb_stb
    );

endmodule

`default_nettype wire

// ==== hw/exec_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_lane (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              issue_valid,
    input  rob_pkg::issue_t   issue,
    output logic              busy,
    output logic              done,
    output rob_pkg::result_t  result,
    input  logic              grant
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MUL,
        S_HOLD
    } state_e;

    state_e      state;
    logic [3:0]  cnt;                           // Multiply steps left
    logic [31:0] mcand;                         // Shifted multiplicand
    logic [11:0] mplier;                        // Remaining multiplier bits
    logic [31:0] a_ext;
    logic [31:0] b_ext;
    logic        start;

    assign a_ext = {20'd0, issue.instr.a};
    assign b_ext = {20'd0, issue.instr.b};
    assign start = (state == S_IDLE) && issue_valid;

    assign busy = (state != S_IDLE);
    assign done = (state == S_HOLD);            // Result stays put until granted

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else if (flush) begin
            state <= S_IDLE;                    // Drop in-flight work
        end else begin
            case (state)
                S_IDLE: begin
                    if (issue_valid) begin
                        if (issue.instr.op == rob_pkg::OP_MUL) begin
                            state <= S_MUL;
                            cnt   <= 4'd11;     // First step done at issue
                        end else begin
                            state <= S_HOLD;
                        end
                    end
                end
                S_MUL: begin
                    cnt <= cnt - 4'd1;
                    if (cnt == 4'd1) begin
                        state <= S_HOLD;        // Done 12 cycles after issue
                    end
                end
                S_HOLD: begin
                    if (grant) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result.tag   <= issue.tag;
            result.fault <= 1'b0;
            mcand        <= a_ext << 1;
            mplier       <= issue.instr.b >> 1;
            case (issue.instr.op)
                rob_pkg::OP_ADD: result.value <= a_ext + b_ext;
                rob_pkg::OP_SUB: result.value <= a_ext - b_ext;     // Wraps
                rob_pkg::OP_XOR: result.value <= a_ext ^ b_ext;
                rob_pkg::OP_MUL: result.value <= issue.instr.b[0] ? a_ext : 32'd0;
                rob_pkg::OP_FAULT: begin
                    result.value <= 32'd0;
                    result.fault <= 1'b1;
                end
                default: result.value <= 32'd0;
            endcase
        end else if (state == S_MUL) begin
            if (mplier[0]) begin
                result.value <= result.value + mcand;   // Accumulate partial product
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    a_no_issue_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        issue_valid |-> !busy
    );

endmodule

`default_nettype wire

// ==== hw/completion_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module completion_arbiter #(
    parameter int NUM_LANES = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic [NUM_LANES-1:0]  lane_done,
    input  rob_pkg::result_t      lane_result [NUM_LANES],
    output logic [NUM_LANES-1:0]  grant,
    output logic                  wb_valid,
    output rob_pkg::result_t      wb_result
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0] ptr;                      // Lane with top priority
    logic [PTR_W-1:0] win;

    // Scan from ptr upward with wrap, first done lane wins
    always_comb begin
        int   idx;
        logic found;
        found = 1'b0;
        win   = '0;
        grant = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            idx = int'(ptr) + i;
            if (idx >= NUM_LANES) begin
                idx = idx - NUM_LANES;
            end
            if (!found && lane_done[idx]) begin
                found = 1'b1;
                win   = PTR_W'(idx);
            end
        end
        if (found && !flush) begin          // Stale results die with the flush
            grant[win] = 1'b1;
        end
    end

    assign wb_valid  = |grant;
    assign wb_result = lane_result[win];    // No added cycle

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ptr <= '0;
        end else if (wb_valid) begin
            if (win == PTR_W'(NUM_LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= win + 1'b1;          // Move past the winner
            end
        end
    end

    a_grant_onehot0: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(grant)
    );

endmodule

`default_nettype wire

// ==== hw/rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob #(
    parameter int DEPTH = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc,
    input  logic                      alloc_fault,
    input  logic [4:0]                alloc_dest,
    output logic [rob_pkg::TAG_W-1:0] alloc_tag,
    output logic                      full,
    input  logic                      wb_valid,
    input  rob_pkg::result_t          wb_result,
    output logic                      commit_valid,
    output rob_pkg::commit_t          commit,
    output logic                      flush
);

    localparam int IDX_W = $clog2(DEPTH);

    typedef struct packed {
        logic        fault;                     // From opcode or lane
        logic [4:0]  dest;
        logic [31:0] value;
    } entry_t;

    entry_t           mem [DEPTH];
    logic [DEPTH-1:0] entry_valid;
    logic [DEPTH-1:0] entry_ready;
    logic [IDX_W:0]   head;                     // MSB is the wrap bit
    logic [IDX_W:0]   tail;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;
    logic [IDX_W-1:0] wb_idx;
    logic             do_alloc;
    logic             head_ok;                  // Head entry can retire
    logic             head_fault;

    assign head_idx = head[IDX_W-1:0];
    assign tail_idx = tail[IDX_W-1:0];
    assign wb_idx   = wb_result.tag[IDX_W-1:0]; // Tag is the slot index

    assign full      = (head[IDX_W] != tail[IDX_W]) && (head_idx == tail_idx);
    assign alloc_tag = rob_pkg::TAG_W'(tail_idx);
    assign do_alloc  = alloc && !full;

    assign head_ok    = entry_valid[head_idx] && entry_ready[head_idx];
    assign head_fault = mem[head_idx].fault;

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            entry_valid  <= '0;
            entry_ready  <= '0;
            commit_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= 1'b0;
            flush        <= 1'b0;
            if (do_alloc) begin
                entry_valid[tail_idx] <= 1'b1;
                entry_ready[tail_idx] <= 1'b0;
                tail                  <= tail + 1'b1;
            end
            if (wb_valid) begin
                entry_ready[wb_idx] <= 1'b1;    // Commit may follow next edge
            end
            if (head_ok) begin
                commit_valid <= 1'b1;
                if (head_fault) begin
                    // Exception wipes everything, a same-edge alloc included
                    flush       <= 1'b1;
                    entry_valid <= '0;
                    entry_ready <= '0;
                    head        <= '0;
                    tail        <= '0;
                end else begin
                    entry_valid[head_idx] <= 1'b0;
                    head                  <= head + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            mem[tail_idx].fault <= alloc_fault;
            mem[tail_idx].dest  <= alloc_dest;
        end
        if (wb_valid) begin
            mem[wb_idx].value <= wb_result.value;
            if (wb_result.fault) begin
                mem[wb_idx].fault <= 1'b1;
            end
        end
        if (head_ok) begin
            commit.dest      <= mem[head_idx].dest;
            commit.value     <= head_fault ? 32'd0 : mem[head_idx].value;
            commit.exception <= head_fault;
        end
    end

    a_wb_hits_valid: assert property (
        @(posedge clk) disable iff (rst)
        wb_valid |-> entry_valid[wb_idx]
    );

endmodule

`default_nettype wire

// ==== hw/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_top #(
    parameter int DEPTH     = 16,
    parameter int NUM_LANES = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [31:0]      wb_dat_w,
    output logic             wb_ack,
    output logic [31:0]      wb_dat_r,
    output logic             commit_valid,
    output rob_pkg::commit_t commit
);

    logic [rob_pkg::TAG_W-1:0] alloc_tag;
    logic                      alloc;
    logic                      alloc_fault;
    logic [4:0]                alloc_dest;
    logic                      rob_full;
    logic                      flush;          // Exception commit, one cycle
    logic [NUM_LANES-1:0]      lane_busy;
    logic [NUM_LANES-1:0]      lane_done;
    logic [NUM_LANES-1:0]      issue_valid;
    logic [NUM_LANES-1:0]      grant;
    rob_pkg::issue_t           issue;          // Shared by all lanes
    rob_pkg::result_t          lane_result [NUM_LANES];
    logic                      wb_valid;
    rob_pkg::result_t          wb_result;

    rob_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) i_dispatch (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_dat_w    (wb_dat_w),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .rob_full    (rob_full),
        .flush       (flush),
        .alloc_tag   (alloc_tag),
        .alloc       (alloc),
        .alloc_fault (alloc_fault),
        .alloc_dest  (alloc_dest),
        .lane_busy   (lane_busy),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        exec_lane i_lane (
            .clk         (clk),
            .rst         (rst),
            .flush       (flush),
            .issue_valid (issue_valid[k]),
            .issue       (issue),
            .busy        (lane_busy[k]),
            .done        (lane_done[k]),
            .result      (lane_result[k]),
            .grant       (grant[k])
        );
    end

    completion_arbiter #(
        .NUM_LANES (NUM_LANES)
    ) i_arbiter (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .lane_done   (lane_done),
        .lane_result (lane_result),
        .grant       (grant),
        .wb_valid    (wb_valid),
        .wb_result   (wb_result)
    );

    rob #(
        .DEPTH (DEPTH)
    ) i_rob (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .alloc_fault  (alloc_fault),
        .alloc_dest   (alloc_dest),
        .alloc_tag    (alloc_tag),
        .full         (rob_full),
        .wb_valid     (wb_valid),
        .wb_result    (wb_result),
        .commit_valid (commit_valid),
        .commit       (commit),
        .flush        (flush)
    );

endmodule

`default_nettype wire

// ==== tb/tb_rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rob_top;

    localparam int          CLK_PERIOD = 8;
    localparam int          DEPTH      = 4;             // Small ROB so it fills up
    localparam int          NUM_LANES  = 3;
    localparam int          NUM_ROWS   = 25;
    localparam int          NUM_RAND   = 200;
    localparam logic [31:0] LFSR_SEED  = 32'hf147;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;  // x^32+x^22+x^2+x+1

    typedef struct packed {
        rob_pkg::instr_t instr;
        logic [31:0]     value;                         // Hand-computed result
        logic            drain;                         // Wait for all commits after it
    } row_t;

    logic             clk;
    logic             rst;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [31:0]      wb_dat_w;
    logic             wb_ack;
    logic [31:0]      wb_dat_r;
    logic             commit_valid;
    rob_pkg::commit_t commit;

    row_t             rows [NUM_ROWS];
    rob_pkg::commit_t exp_q [$];                        // Acked words not yet committed
    rob_pkg::commit_t cur_exp;                          // Expected commit of word on bus
    logic [31:0]      lfsr;
    int               errors      = 0;
    int               n_acks      = 0;
    int               n_commits   = 0;
    int               n_discarded = 0;
    int               n_exc       = 0;

    rob_top #(
        .DEPTH     (DEPTH),
        .NUM_LANES (NUM_LANES)
    ) i_rob_top (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .wb_dat_r     (wb_dat_r),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // One output bit per LFSR step
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return bits;
    endfunction

    // Reference model with zero-extended operands and results mod 2^32
    function automatic logic [31:0] ref_value(input rob_pkg::instr_t ins);
        logic [31:0] a;
        logic [31:0] b;
        a = {20'd0, ins.a};
        b = {20'd0, ins.b};
        case (ins.op)
            rob_pkg::OP_ADD: return a + b;
            rob_pkg::OP_SUB: return a - b;
            rob_pkg::OP_XOR: return a ^ b;
            rob_pkg::OP_MUL: return a * b;
            default:         return 32'd0;
        endcase
    endfunction

    function automatic row_t make_row(input rob_pkg::rob_op_e op, input logic [4:0] dest,
                                      input logic [11:0] a, input logic [11:0] b,
                                      input logic [31:0] value, input logic drain);
        row_t r;
        r.instr.op   = op;
        r.instr.dest = dest;
        r.instr.a    = a;
        r.instr.b    = b;
        r.value      = value;
        r.drain      = drain;
        return r;
    endfunction

    task automatic load_table();
        // Single-cycle ops back to back
        rows[0]  = make_row(rob_pkg::OP_ADD, 5'd1, 12'h123, 12'h456, 32'h0000_0579, 1'b0);
        rows[1]  = make_row(rob_pkg::OP_SUB, 5'd2, 12'h005, 12'h009, 32'hFFFF_FFFC, 1'b0);
        rows[2]  = make_row(rob_pkg::OP_XOR, 5'd3, 12'hF0F, 12'h0FF, 32'h0000_0FF0, 1'b0);
        rows[3]  = make_row(rob_pkg::OP_ADD, 5'd4, 12'hFFF, 12'hFFF, 32'h0000_1FFE, 1'b0);
        // Slow multiply ahead of quick ops
        rows[4]  = make_row(rob_pkg::OP_MUL, 5'd5, 12'hFFF, 12'hFFF, 32'h00FF_E001, 1'b0);
        rows[5]  = make_row(rob_pkg::OP_ADD, 5'd6, 12'h001, 12'h002, 32'h0000_0003, 1'b0);
        rows[6]  = make_row(rob_pkg::OP_SUB, 5'd7, 12'h010, 12'h001, 32'h0000_000F, 1'b0);
        rows[7]  = make_row(rob_pkg::OP_XOR, 5'd8, 12'hAAA, 12'h555, 32'h0000_0FFF, 1'b1);
        // Burst longer than DEPTH behind multiplies
        rows[8]  = make_row(rob_pkg::OP_MUL, 5'd13, 12'h0FF, 12'h101, 32'h0000_FFFF, 1'b0);
        rows[9]  = make_row(rob_pkg::OP_MUL, 5'd14, 12'h800, 12'h800, 32'h0040_0000, 1'b0);
        rows[10] = make_row(rob_pkg::OP_ADD, 5'd15, 12'h7FF, 12'h001, 32'h0000_0800, 1'b0);
        rows[11] = make_row(rob_pkg::OP_ADD, 5'd16, 12'h001, 12'h001, 32'h0000_0002, 1'b0);
        rows[12] = make_row(rob_pkg::OP_SUB, 5'd17, 12'h000, 12'hFFF, 32'hFFFF_F001, 1'b0);
        rows[13] = make_row(rob_pkg::OP_XOR, 5'd18, 12'h123, 12'h321, 32'h0000_0202, 1'b0);
        rows[14] = make_row(rob_pkg::OP_ADD, 5'd19, 12'h100, 12'h200, 32'h0000_0300, 1'b0);
        rows[15] = make_row(rob_pkg::OP_MUL, 5'd20, 12'h003, 12'h007, 32'h0000_0015, 1'b0);
        rows[16] = make_row(rob_pkg::OP_ADD, 5'd21, 12'hFFF, 12'h000, 32'h0000_0FFF, 1'b0);
        rows[17] = make_row(rob_pkg::OP_SUB, 5'd22, 12'h800, 12'h800, 32'h0000_0000, 1'b1);
        // Fault whose younger word dies in the flush
        rows[18] = make_row(rob_pkg::OP_ADD, 5'd9, 12'h002, 12'h002, 32'h0000_0004, 1'b0);
        rows[19] = make_row(rob_pkg::OP_FAULT, 5'd10, 12'h000, 12'h000, 32'h0000_0000, 1'b0);
        rows[20] = make_row(rob_pkg::OP_ADD, 5'd11, 12'h001, 12'h001, 32'h0000_0002, 1'b0);
        rows[21] = make_row(rob_pkg::OP_ADD, 5'd12, 12'h003, 12'h003, 32'h0000_0006, 1'b1);
        // Restart after the flush
        rows[22] = make_row(rob_pkg::OP_ADD, 5'd23, 12'h00A, 12'h005, 32'h0000_000F, 1'b0);
        rows[23] = make_row(rob_pkg::OP_MUL, 5'd24, 12'h00C, 12'h00D, 32'h0000_009C, 1'b0);
        rows[24] = make_row(rob_pkg::OP_XOR, 5'd25, 12'hFFF, 12'h001, 32'h0000_0FFE, 1'b1);
    endtask

    // Starts on a rising edge and returns on the ack edge
    task automatic write_word(input rob_pkg::instr_t ins, input rob_pkg::commit_t exp);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_dat_w = ins;
        cur_exp  = exp;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);                 // Wait states while stalled
    endtask

    task automatic release_bus(input int n);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic read_word();
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);
        if (wb_dat_r !== 32'd0) begin
            $display("Error at %0t: wb_dat_r expected %h got %h", $time, 32'd0, wb_dat_r);
            errors++;
        end
        release_bus(1);
    endtask

    task automatic wait_drain();
        release_bus(1);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);                      // Let any stray commit show up
    endtask

    // Checks each commit before recording the ack of the same edge
    always @(posedge clk) begin : monitor
        rob_pkg::commit_t exp;
        if (!rst) begin
            if (commit_valid) begin
                n_commits++;                            // Every pulse, expected or not
                if (commit.exception === 1'b1) begin
                    n_exc++;
                end
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: commit seen with no write outstanding", $time);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    if (commit.dest !== exp.dest) begin
                        $display("Error at %0t: commit.dest expected %h got %h",
                                 $time, exp.dest, commit.dest);
                        errors++;
                    end
                    if (commit.value !== exp.value) begin
                        $display("Error at %0t: commit.value expected %h got %h",
                                 $time, exp.value, commit.value);
                        errors++;
                    end
                    if (commit.exception !== exp.exception) begin
                        $display("Error at %0t: commit.exception expected %b got %b",
                                 $time, exp.exception, commit.exception);
                        errors++;
                    end
                    if (exp.exception) begin
                        n_discarded += exp_q.size();    // Younger words are flushed
                        exp_q.delete();
                    end
                end
            end
            if (wb_ack && wb_we) begin
                exp_q.push_back(cur_exp);
                n_acks++;
            end
        end
    end

    initial begin : stimulus
        rob_pkg::instr_t  ins;
        rob_pkg::commit_t exp;
        int               gap;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_dat_w = '0;
        rst      = 1'b1;
        cur_exp  = '0;
        lfsr     = LFSR_SEED;
        load_table();
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);

        read_word();

        for (int i = 0; i < NUM_ROWS; i++) begin
            exp.dest      = rows[i].instr.dest;
            exp.value     = rows[i].value;
            exp.exception = (rows[i].instr.op == rob_pkg::OP_FAULT);
            write_word(rows[i].instr, exp);
            if (rows[i].drain) begin
                wait_drain();
            end
        end

        // Random mix without faults
        for (int i = 0; i < NUM_RAND; i++) begin
            ins.op        = rob_pkg::rob_op_e'(3'(lfsr_bits(2)));   // ADD..MUL only
            ins.dest      = 5'(lfsr_bits(5));
            ins.a         = 12'(lfsr_bits(12));
            ins.b         = 12'(lfsr_bits(12));
            gap           = int'(lfsr_bits(2));
            exp.dest      = ins.dest;
            exp.value     = ref_value(ins);
            exp.exception = 1'b0;
            write_word(ins, exp);
            if (gap != 0) begin
                release_bus(gap);
            end
        end
        wait_drain();

        if (n_acks != n_commits + n_discarded) begin
            $display("Error at %0t: %0d writes acked but %0d committed and %0d flushed",
                     $time, n_acks, n_commits, n_discarded);
            errors++;
        end
        if (n_exc != 1) begin
            $display("Error at %0t: n_exc expected %0d got %0d", $time, 1, n_exc);
            errors++;
        end
        if (n_discarded < 1) begin
            $display("Error at %0t: the exception flush discarded no younger write", $time);
            errors++;
        end

        $display("Summary: %0d acked, %0d committed, %0d flushed, %0d exceptions, %0d errors",
                 n_acks, n_commits, n_discarded, n_exc, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog allows about 40 cycles per instruction
    initial begin : watchdog
        #((NUM_ROWS + NUM_RAND) * 40 * CLK_PERIOD);
        $display("Timeout at %0t: the run did not finish in time, %0d errors so far",
                 $time, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/rob_pkg.sv
hw/rob_dispatch.sv
hw/exec_lane.sv
hw/completion_arbiter.sv
hw/rob.sv
hw/rob_top.sv
tb/tb_rob_top.sv

// ==== Bender.yml ====
package:
  name: rob_core

sources:
  - hw/rob_pkg.sv
  - hw/rob_dispatch.sv
  - hw/exec_lane.sv
  - hw/completion_arbiter.sv
  - hw/rob.sv
  - hw/rob_top.sv
  - target: simulation
    files:
      - tb/tb_rob_top.sv
